// File: hw/clearCounter.sv
// --------------------
// clearCounter: walks r1..r31 once after reset,
// one per cycle, and flags when it is done
// --------------------
module clearCounter import grfPkg::*; (
    input  logic    clk,
    input  logic    rst,
    output logic    clearing,
    output regAddrT clrAddr
);

    // last entry to zero
    localparam regAddrT LAST_ADDR = 5'd31;

    always_ff @(posedge clk) begin
        if (rst) begin
            // r0 is skipped, start at r1
            clrAddr  <= 5'd1;
            clearing <= 1'b1;
        end else if (clearing) begin
            if (clrAddr == LAST_ADDR) begin
                // r31 written on this edge
                clearing <= 1'b0;
            end else begin
                clrAddr <= clrAddr + 5'd1;
            end
        end
    end

endmodule

// File: hw/grf.sv
// --------------------
// grf: 32-entry general register file, two async
// read ports, one sync write port shared with clear
// --------------------
module grf import grfPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  regAddrT              rAddr1,
    input  regAddrT              rAddr2,
    output logic [dataWidth-1:0] rData1,
    output logic [dataWidth-1:0] rData2,
    input  wbRecT                rec,
    input  logic                 commit,
    input  logic                 writeEn,
    input  logic                 clearing,
    input  regAddrT              clrAddr
);

    // storage, entry 0 is never read back
    logic [dataWidth-1:0] regs [32];

    logic commitWr;

    // commit write needs the id gate and a real target
    assign commitWr = !rst && commit && writeEn && (rec.wAddr != '0);

    // clear sequence has priority over commits
    always_ff @(posedge clk) begin
        if (clearing) begin
            regs[clrAddr] <= '0;
        end else if (commitWr) begin
            regs[rec.wAddr] <= rec.wData[dataWidth-1:0];
        end
    end

    // r0 forced to zero on the read side
    assign rData1 = (rAddr1 == '0) ? '0 : regs[rAddr1];
    assign rData2 = (rAddr2 == '0) ? '0 : regs[rAddr2];

endmodule

// File: hw/grfPkg.sv
// --------------------
// grfPkg: shared types and bus offsets for the
// register file and its write-back bus slave
// --------------------
package grfPkg;

    // register index, r0 is hardwired to zero
    typedef logic [4:0] regAddrT;

    // instruction ids as carried through write-back
    // NOP is 0, the rest ascend in listed order
    typedef enum logic [5:0] {
        NOP  = 6'd0,
        ADDU,
        SUBU,
        ORI,
        LUI,
        AND,
        SLL,
        LW,
        SW,
        BEQ,
        J,
        JAL,
        JR,
        JALR
    } instrIdT;

    // functional classes
    typedef enum logic [2:0] {
        FUNC_NOP,
        FUNC_ARITH,
        FUNC_LOGICAL,
        FUNC_SHIFT,
        FUNC_MEMLOAD,
        FUNC_MEMSTORE,
        FUNC_BRANCH,
        FUNC_JUMP
    } funcTypeT;

    // one write-back record, staged over the bus
    // pc stays 32 bits whatever the data width
    typedef struct packed {
        logic [31:0] pc;
        instrIdT     instr;
        regAddrT     wAddr;
        logic [31:0] wData;
    } wbRecT;

    // word offsets on the slave
    localparam logic [1:0] ADR_PC     = 2'd0;
    // bits 5:0 id, bits 12:8 destination
    localparam logic [1:0] ADR_DEST   = 2'd1;
    // write here commits the record
    localparam logic [1:0] ADR_DATA   = 2'd2;
    // bit 0 busy clearing, bits 15:8 commit count
    localparam logic [1:0] ADR_STATUS = 2'd3;

endpackage

// File: hw/grfTop.sv
// --------------------
// grfTop: write-back end, bus slave plus register
// file with its clear sequencer and write gating
// --------------------
module grfTop import grfPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    // Wishbone slave
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic [1:0]           adr,
    input  logic [31:0]          datIn,
    output logic [31:0]          datOut,
    output logic                 ack,
    // decode-stage read ports
    input  regAddrT              rAddr1,
    input  regAddrT              rAddr2,
    output logic [dataWidth-1:0] rData1,
    output logic [dataWidth-1:0] rData2
);

    wbRecT    rec;
    logic     commit;
    logic     writeEn;
    logic     clearing;
    regAddrT  clrAddr;

    wbCtrlFsm #(
        .dataWidth(dataWidth)
    ) wbCtrlFsm_inst (
        .clk     (clk),
        .rst     (rst),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .datIn   (datIn),
        .datOut  (datOut),
        .ack     (ack),
        .clearing(clearing),
        .writeEn (writeEn),
        .rec     (rec),
        .commit  (commit)
    );

    // class only feeds the write gate here
    instrCategorizer instrCategorizer_inst (
        .instr   (rec.instr),
        .funcType(),
        .writeEn (writeEn)
    );

    clearCounter clearCounter_inst (
        .clk     (clk),
        .rst     (rst),
        .clearing(clearing),
        .clrAddr (clrAddr)
    );

    grf #(
        .dataWidth(dataWidth)
    ) grf_inst (
        .clk     (clk),
        .rst     (rst),
        .rAddr1  (rAddr1),
        .rAddr2  (rAddr2),
        .rData1  (rData1),
        .rData2  (rData2),
        .rec     (rec),
        .commit  (commit),
        .writeEn (writeEn),
        .clearing(clearing),
        .clrAddr (clrAddr)
    );

endmodule

// File: hw/instrCategorizer.sv
// --------------------
// instrCategorizer: sorts a write-back id into its
// functional class and decides the register write
// --------------------
module instrCategorizer import grfPkg::*; (
    input  instrIdT  instr,
    output funcTypeT funcType,
    output logic     writeEn
);

    always_comb begin
        case (instr)
            NOP:  funcType = FUNC_NOP;
            // arithmetic
            ADDU: funcType = FUNC_ARITH;
            SUBU: funcType = FUNC_ARITH;
            // logical, LUI counts here too
            ORI:  funcType = FUNC_LOGICAL;
            LUI:  funcType = FUNC_LOGICAL;
            AND:  funcType = FUNC_LOGICAL;
            SLL:  funcType = FUNC_SHIFT;
            // memory
            LW:   funcType = FUNC_MEMLOAD;
            SW:   funcType = FUNC_MEMSTORE;
            // control flow
            BEQ:  funcType = FUNC_BRANCH;
            J:    funcType = FUNC_JUMP;
            JAL:  funcType = FUNC_JUMP;
            JR:   funcType = FUNC_JUMP;
            JALR: funcType = FUNC_JUMP;
            // unknown ids behave as a bubble
            default: funcType = FUNC_NOP;
        endcase
    end

    // only result-producing classes write back
    // jumps write only when they link (ra / rd)
    assign writeEn = (funcType == FUNC_ARITH)
                  || (funcType == FUNC_LOGICAL)
                  || (funcType == FUNC_SHIFT)
                  || (funcType == FUNC_MEMLOAD)
                  || (instr == JAL)
                  || (instr == JALR);

endmodule

// File: hw/wbCtrlFsm.sv
// --------------------
// wbCtrlFsm: Wishbone classic slave that stages the
// write-back record and strobes each commit
// --------------------
module wbCtrlFsm import grfPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] datIn,
    output logic [31:0] datOut,
    output logic        ack,
    input  logic        clearing,
    input  logic        writeEn,
    output wbRecT       rec,
    output logic        commit
);

    typedef enum logic [1:0] {
        WAIT_CLEAR,
        IDLE,
        ACK,
        HOLD
    } stateT;

    stateT       state;
    logic        req;
    logic [7:0]  commitCnt;
    // staged record fields
    logic [31:0] pcReg;
    instrIdT     instrReg;
    regAddrT     wAddrReg;

    // new request only once the clear is over
    assign req = (state == IDLE) && cyc && stb;

    // data write commits on the edge that raises ack
    assign commit = req && we && (adr == ADR_DATA);

    // data word passes straight through trimmed to the datapath
    assign rec.pc    = pcReg;
    assign rec.instr = instrReg;
    assign rec.wAddr = wAddrReg;
    assign rec.wData = 32'(datIn[dataWidth-1:0]);

    // single-cycle ack
    assign ack = (state == ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= WAIT_CLEAR;
            commitCnt <= '0;
        end else begin
            // counts gated writes and wraps at 255
            if (commit && writeEn) begin
                commitCnt <= commitCnt + 8'd1;
            end
            case (state)
                WAIT_CLEAR: if (!clearing) state <= IDLE;
                IDLE:       if (req) state <= ACK;
                // host still holding stb so wait for it to drop
                ACK:        state <= stb ? HOLD : IDLE;
                HOLD:       if (!stb) state <= IDLE;
                default:    state <= WAIT_CLEAR;
            endcase
        end
    end

    // staged payload and read data
    always_ff @(posedge clk) begin
        if (req && we) begin
            case (adr)
                ADR_PC: pcReg <= datIn;
                ADR_DEST: begin
                    instrReg <= instrIdT'(datIn[5:0]);
                    wAddrReg <= datIn[12:8];
                end
                default: ;
            endcase
        end else if (req) begin
            // read data lands with ack
            case (adr)
                ADR_PC:     datOut <= pcReg;
                ADR_DEST:   datOut <= {19'd0, wAddrReg, 2'd0, instrReg};
                ADR_STATUS: datOut <= {16'd0, commitCnt, 7'd0, clearing};
                default:    datOut <= '0;
            endcase
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the register file testbench with Verilator and run it.
# Exit status is 0 only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module grfTb \
    -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "run.sh: verilator build failed"
    exit 1
fi

./obj_dir/VgrfTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "run.sh: simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "run.sh: pass line not found in $LOG"
exit 1

// File: test/wbHostTasks.svh
// --------------------
// Wishbone classic host tasks, driven on the falling
// edge, and the three-word record commit
// --------------------
`ifndef WB_HOST_TASKS_SVH
`define WB_HOST_TASKS_SVH

    // look for ack on each falling edge, give up after ACK_TIMEOUT
    task automatic waitAck(output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
            if (ack === 1'b1) begin
                ok = 1'b1;
            end
        end
        lastWait = n;
        if (!ok) begin
            $display("timeout, no ack from the bus slave within %0d cycles", ACK_TIMEOUT);
            errCount++;
        end
    endtask

    task automatic wbWrite(input logic [1:0] a, input logic [31:0] d);
        logic ok;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        datIn = d;
        waitAck(ok);
        // drop the request on the edge ack was seen
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wbRead(input logic [1:0] a, output logic [31:0] d);
        logic ok;
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        waitAck(ok);
        // read data is valid alongside ack
        d   = datOut;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    // pc, then id and destination, then data which commits
    task automatic commitRec(input logic [31:0] pc, input logic [5:0] id,
                             input regAddrT a, input logic [31:0] d);
        wbWrite(ADR_PC, pc);
        wbWrite(ADR_DEST, {19'd0, a, 2'd0, id});
        wbWrite(ADR_DATA, d);
    endtask

    // poll busy until it drops, limited number of reads
    task automatic waitClearDone();
        logic [31:0] stat;
        int          tries;
        tries = 0;
        stat  = 32'd1;
        while (stat[0] === 1'b1 && tries < POLL_LIMIT) begin
            wbRead(ADR_STATUS, stat);
            tries++;
        end
        if (stat[0] !== 1'b0) begin
            $display("busy flag still set after %0d status reads", tries);
            errCount++;
        end
    endtask

`endif

// File: test/grfTb.sv
// --------------------
// grfTb: random testbench for the write-back register
// file, checked against a reference model
// --------------------
module grfTb import grfPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int dataWidth   = 32;
    localparam int ACK_TIMEOUT = 100;
    localparam int POLL_LIMIT  = 20;
    localparam int NUM_COMMITS = 200;
    localparam int NUM_SWEEPS  = 64;

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [1:0]           adr;
    logic [31:0]          datIn;
    logic [31:0]          datOut;
    logic                 ack;
    regAddrT              rAddr1;
    regAddrT              rAddr2;
    logic [dataWidth-1:0] rData1;
    logic [dataWidth-1:0] rData2;

    // reference model, registers plus gated commit count
    logic [31:0] model [32];
    logic [7:0]  modelCnt;
    int          errCount;
    int          testsPassed;
    int          testsFailed;
    // cycles spent in the last wait for ack
    int          lastWait;

    grfTop #(
        .dataWidth(dataWidth)
    ) grfTop_inst (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datIn (datIn),
        .datOut(datOut),
        .ack   (ack),
        .rAddr1(rAddr1),
        .rAddr2(rAddr2),
        .rData1(rData1),
        .rData2(rData2)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

`include "wbHostTasks.svh"

    // result-producing classes, loads and linking jumps write
    // anything else, unknown ids too, leaves the file alone
    function automatic logic idWrites(input logic [5:0] id);
        case (id)
            ADDU, SUBU, ORI, LUI, AND, SLL, LW, JAL, JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic applyModel(input logic [5:0] id, input regAddrT a, input logic [31:0] d);
        if (idWrites(id)) begin
            modelCnt = modelCnt + 8'd1;
            // r0 stays zero
            if (a != 5'd0) begin
                model[a] = d;
            end
        end
    endtask

    task automatic clearModel();
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'd0;
        end
        modelCnt = 8'd0;
    endtask

    // set both read addresses, compare one cycle later
    task automatic checkPorts(input regAddrT a1, input regAddrT a2);
        @(negedge clk);
        rAddr1 = a1;
        rAddr2 = a2;
        @(negedge clk);
        if (rData1 !== model[a1]) begin
            $display("Fail rData1 r%0d exp %h got %h", a1, model[a1], rData1);
            errCount++;
        end
        if (rData2 !== model[a2]) begin
            $display("Fail rData2 r%0d exp %h got %h", a2, model[a2], rData2);
            errCount++;
        end
    endtask

    // every entry through both ports, port 2 walks backwards
    task automatic checkAllRegs();
        for (int i = 0; i < 32; i++) begin
            checkPorts(5'(i), 5'(31 - i));
        end
    endtask

    task automatic checkCount();
        logic [31:0] stat;
        wbRead(ADR_STATUS, stat);
        if (stat[15:8] !== modelCnt) begin
            $display("Fail status.count exp %h got %h", modelCnt, stat[15:8]);
            errCount++;
        end
    endtask

    // writing id aimed at r0
    task automatic zeroTarget(input logic [5:0] id);
        logic [31:0] d;
        d = $urandom;
        commitRec(32'h0000_0400, id, 5'd0, d);
        applyModel(id, 5'd0, d);
        checkPorts(5'd0, 5'd0);
    endtask

    task automatic pulseReset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        clearModel();
    endtask

    task automatic finishTest(input string name, input int errsAt);
        if (errCount == errsAt) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errCount - errsAt);
        end
    endtask

    initial begin
        int          errsAt;
        logic [31:0] stat;
        logic [5:0]  id;
        regAddrT     a;
        logic [31:0] d;
        void'($urandom(32'h8244_aa20));
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = 2'd0;
        datIn       = 32'd0;
        rAddr1      = 5'd0;
        rAddr2      = 5'd0;
        rst         = 1'b1;
        errCount    = 0;
        testsPassed = 0;
        testsFailed = 0;
        lastWait    = 0;
        clearModel();
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // status read during the clear is held off until it ends
        errsAt = errCount;
        wbRead(ADR_STATUS, stat);
        if (lastWait < 31) begin
            $display("status read was acked after %0d cycles, before the clear ended", lastWait);
            errCount++;
        end
        waitClearDone();
        checkAllRegs();
        checkCount();
        finishTest("clear after reset", errsAt);

        errsAt = errCount;
        for (int n = 0; n < NUM_COMMITS; n++) begin
            id = 6'($urandom_range(15, 0));
            a  = 5'($urandom_range(31, 0));
            d  = $urandom;
            commitRec($urandom, id, a, d);
            applyModel(id, a, d);
            checkPorts(a, a);
        end
        finishTest("write gating by class", errsAt);

        errsAt = errCount;
        zeroTarget(ADDU);
        zeroTarget(LW);
        zeroTarget(JAL);
        zeroTarget(JALR);
        finishTest("register 0", errsAt);

        errsAt = errCount;
        for (int n = 0; n < NUM_SWEEPS; n++) begin
            checkPorts(5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)));
        end
        finishTest("independent read ports", errsAt);

        errsAt = errCount;
        checkCount();
        finishTest("commit count", errsAt);

        // second reset, array and counter come back zeroed
        errsAt = errCount;
        pulseReset();
        waitClearDone();
        checkAllRegs();
        checkCount();
        finishTest("reset in mid-run", errsAt);

        $display("tests ok %0d, tests failing %0d, errors %0d", testsPassed, testsFailed, errCount);
        if (errCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+test
hw/grfPkg.sv
hw/instrCategorizer.sv
hw/clearCounter.sv
hw/grf.sv
hw/wbCtrlFsm.sv
hw/grfTop.sv
test/grfTb.sv
